//--- design/cpu_pkg.sv
package cpu_pkg;

	typedef logic [15:0] word_t;
	typedef logic [7:0] byte_t;

	typedef enum logic [7:0] {
		op_trap        = 8'h00,
		op_sub_xl_immd = 8'h10,
		op_sub_xl_dir  = 8'h11,
		op_add_xl_immd = 8'h18,
		op_add_xl_dir  = 8'h19,
		op_cp_xl_immd  = 8'h20,
		op_cp_xl_dir   = 8'h21,
		op_or_xl_immd  = 8'h28,
		op_or_xl_dir   = 8'h29,
		op_and_xl_immd = 8'h30,
		op_and_xl_dir  = 8'h31,
		op_xor_xl_immd = 8'h38,
		op_xor_xl_dir  = 8'h39,
		op_inc_xl      = 8'h58,
		op_ld_xl_immd  = 8'h90,
		op_ld_xl_dir   = 8'h91,
		op_ld_xl_yrel  = 8'h93,
		op_ld_dir_xl   = 8'h94,
		op_ld_yrel_xl  = 8'h96,
		op_ldw_y_immd  = 8'hb0,
		op_ldw_x_y     = 8'hc8,
		op_ldw_z_y     = 8'hc9,
		op_jr_d        = 8'hd0,
		op_jrz_d       = 8'hd1,
		op_jrnz_d      = 8'hd2,
		op_jrc_d       = 8'hd3,
		op_jrnc_d      = 8'hd4
	} opcode_t;

	// opcode in the low byte, operand bytes follow
	typedef struct packed {
		byte_t unused;
		byte_t imm8;
		opcode_t opcode;
	} inst8_t;

	typedef struct packed {
		word_t imm16;
		opcode_t opcode;
	} inst16_t;

	typedef union packed {
		inst8_t s;
		inst16_t w;
	} inst_u;

	typedef enum logic [2:0] {
		alu_pass, alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_inc
	} alu_op_t;

	typedef enum logic [1:0] {src_imm8, src_imm16, src_mem, src_y} src_t;
	typedef enum logic {am_dir, am_yrel} amode_t;

	typedef enum logic [2:0] {
		cond_none, cond_always, cond_z, cond_nz, cond_c, cond_nc
	} cond_t;

	typedef struct packed {
		logic c;
		logic n;
		logic z;
		logic o;
	} flags_t;

	typedef struct packed {
		alu_op_t alu_op;
		src_t src;
		logic [1:0] reg_sel;
		logic [1:0] reg_be;
		logic cmp;
		logic mem_write;
		amode_t amode;
		flags_t flag_mask;
		cond_t cond;
		logic trap;
		logic [1:0] len;
	} ctrl_t;

endpackage

//--- design/decoder.sv
`timescale 1ns/1ps

module decoder (
	input cpu_pkg::inst_u inst,
	input logic reset,
	output cpu_pkg::ctrl_t ctrl
);
	import cpu_pkg::*;

	localparam flags_t fm_arith = '{c: 1'b1, n: 1'b1, z: 1'b1, o: 1'b1};
	localparam flags_t fm_logic = '{c: 1'b0, n: 1'b1, z: 1'b1, o: 1'b0};
	localparam flags_t fm_inc = '{c: 1'b1, n: 1'b0, z: 1'b1, o: 1'b1};

	opcode_t op;

	assign op = inst.s.opcode;

	always_comb
	begin
		// unknown opcodes fall through as one-byte no-ops
		ctrl = '0;
		ctrl.len = 2'd1;

		// operand source, destination and length
		case (op)
			op_add_xl_immd, op_sub_xl_immd, op_cp_xl_immd, op_and_xl_immd,
			op_or_xl_immd, op_xor_xl_immd, op_ld_xl_immd:
			begin
				ctrl.src = src_imm8;
				ctrl.reg_be = 2'b01;
				ctrl.len = 2'd2;
			end
			op_add_xl_dir, op_sub_xl_dir, op_cp_xl_dir, op_and_xl_dir,
			op_or_xl_dir, op_xor_xl_dir, op_ld_xl_dir:
			begin
				ctrl.src = src_mem;
				ctrl.amode = am_dir;
				ctrl.reg_be = 2'b01;
				ctrl.len = 2'd3;
			end
			op_inc_xl:
				ctrl.reg_be = 2'b01;
			op_ld_xl_yrel:
			begin
				ctrl.src = src_mem;
				ctrl.amode = am_yrel;
				ctrl.reg_be = 2'b01;
				ctrl.len = 2'd2;
			end
			op_ld_dir_xl:
			begin
				ctrl.mem_write = 1'b1;
				ctrl.amode = am_dir;
				ctrl.len = 2'd3;
			end
			op_ld_yrel_xl:
			begin
				ctrl.mem_write = 1'b1;
				ctrl.amode = am_yrel;
				ctrl.len = 2'd2;
			end
			op_ldw_y_immd:
			begin
				ctrl.src = src_imm16;
				ctrl.reg_sel = 2'd1;
				ctrl.reg_be = 2'b11;
				ctrl.len = 2'd3;
			end
			op_ldw_x_y, op_ldw_z_y:
			begin
				ctrl.src = src_y;
				ctrl.reg_sel = (op == op_ldw_z_y) ? 2'd2 : 2'd0;
				ctrl.reg_be = 2'b11;
			end
			op_jr_d, op_jrz_d, op_jrnz_d, op_jrc_d, op_jrnc_d:
				ctrl.len = 2'd2;
			op_trap:
				ctrl.trap = !reset;
			default: ;
		endcase

		// operation, flag updates and branch condition
		case (op)
			op_add_xl_immd, op_add_xl_dir:
			begin
				ctrl.alu_op = alu_add;
				ctrl.flag_mask = fm_arith;
			end
			op_sub_xl_immd, op_sub_xl_dir, op_cp_xl_immd, op_cp_xl_dir:
			begin
				ctrl.alu_op = alu_sub;
				ctrl.flag_mask = fm_arith;
				ctrl.cmp = (op == op_cp_xl_immd) || (op == op_cp_xl_dir);
			end
			op_and_xl_immd, op_and_xl_dir:
			begin
				ctrl.alu_op = alu_and;
				ctrl.flag_mask = fm_logic;
			end
			op_or_xl_immd, op_or_xl_dir:
			begin
				ctrl.alu_op = alu_or;
				ctrl.flag_mask = fm_logic;
			end
			op_xor_xl_immd, op_xor_xl_dir:
			begin
				ctrl.alu_op = alu_xor;
				ctrl.flag_mask = fm_logic;
			end
			op_inc_xl:
			begin
				ctrl.alu_op = alu_inc;
				ctrl.flag_mask = fm_inc;
			end
			op_jr_d:
				ctrl.cond = cond_always;
			op_jrz_d:
				ctrl.cond = cond_z;
			op_jrnz_d:
				ctrl.cond = cond_nz;
			op_jrc_d:
				ctrl.cond = cond_c;
			op_jrnc_d:
				ctrl.cond = cond_nc;
			default: ;
		endcase
	end

endmodule

//--- design/alu.sv
`timescale 1ns/1ps

module alu (
	input cpu_pkg::ctrl_t ctrl,
	input cpu_pkg::inst_u inst,
	input cpu_pkg::word_t x,
	input cpu_pkg::word_t y,
	input cpu_pkg::word_t dread_data,
	output cpu_pkg::word_t result,
	output cpu_pkg::flags_t flags_out
);
	import cpu_pkg::*;

	word_t operand;
	byte_t a;
	byte_t b;
	byte_t r;
	logic cy;
	logic ov;

	always_comb
	begin
		case (ctrl.src)
			src_imm8: operand = {8'h00, inst.s.imm8};
			src_imm16: operand = inst.w.imm16;
			src_mem: operand = dread_data;
			default: operand = y;
		endcase
	end

	assign a = x[7:0];
	assign b = operand[7:0];

	always_comb
	begin
		cy = 1'b0;
		ov = 1'b0;
		case (ctrl.alu_op)
			alu_add:
			begin
				{cy, r} = {1'b0, a} + {1'b0, b};
				ov = (a[7] == b[7]) && (r[7] != a[7]);
			end
			alu_sub:
			begin
				// carry holds the borrow
				{cy, r} = {1'b0, a} - {1'b0, b};
				ov = (a[7] != b[7]) && (r[7] != a[7]);
			end
			alu_inc:
			begin
				{cy, r} = {1'b0, a} + 9'd1;
				ov = !a[7] && r[7];
			end
			alu_and: r = a & b;
			alu_or: r = a | b;
			alu_xor: r = a ^ b;
			default: r = b;
		endcase
	end

	// pass keeps the whole word for ldw, 8-bit ops leave xh alone
	assign result = (ctrl.alu_op == alu_pass) ? operand : {x[15:8], r};

	assign flags_out.c = cy;
	assign flags_out.n = r[7];
	assign flags_out.z = (r == 8'h00);
	assign flags_out.o = ov;

endmodule

//--- design/addr_gen.sv
`timescale 1ns/1ps

module addr_gen (
	input cpu_pkg::ctrl_t ctrl,
	input cpu_pkg::inst_u inst,
	input cpu_pkg::word_t y,
	output cpu_pkg::word_t dread_addr,
	output cpu_pkg::word_t dwrite_addr
);
	import cpu_pkg::*;

	word_t addr;

	// displacement is unsigned in y-relative mode
	always_comb
	begin
		if (ctrl.amode == am_yrel)
			addr = y + {8'h00, inst.s.imm8};
		else
			addr = inst.w.imm16;
	end

	assign dread_addr = addr;
	assign dwrite_addr = addr;

endmodule

//--- design/writeback.sv
`timescale 1ns/1ps

module writeback (
	input logic clk,
	input logic reset,
	input cpu_pkg::ctrl_t ctrl,
	input cpu_pkg::word_t result,
	input cpu_pkg::flags_t flags_out,
	input cpu_pkg::word_t x,
	input cpu_pkg::word_t mem_addr,
	output logic [1:0] reg_sel,
	output logic [1:0] reg_be,
	output cpu_pkg::word_t reg_data,
	output cpu_pkg::word_t dwrite_addr,
	output cpu_pkg::word_t dwrite_data,
	output logic [1:0] dwrite_en,
	output cpu_pkg::flags_t flags
);
	import cpu_pkg::*;

	// cp only sets flags
	assign reg_sel = ctrl.reg_sel;
	assign reg_be = (reset || ctrl.cmp) ? 2'b00 : ctrl.reg_be;
	assign reg_data = result;

	// stores are xl only, high byte lane stays off
	assign dwrite_addr = mem_addr;
	assign dwrite_data = x;
	assign dwrite_en = reset ? 2'b00 : {1'b0, ctrl.mem_write};

	always_ff @(posedge clk)
	begin
		if (reset)
			flags <= '0;
		else
			flags <= flags_t'((flags & ~ctrl.flag_mask) | (flags_out & ctrl.flag_mask));
	end

endmodule

//--- design/regfile.sv
`timescale 1ns/1ps

module regfile (
	input logic clk,
	input logic [1:0] sel,
	input logic [1:0] be,
	input cpu_pkg::word_t data,
	output cpu_pkg::word_t x,
	output cpu_pkg::word_t y,
	output cpu_pkg::word_t z
);
	import cpu_pkg::*;

	// 0 is x, 1 is y, 2 is z
	word_t regs [3];

	always_ff @(posedge clk)
	begin
		if (be[0])
			regs[sel][7:0] <= data[7:0];
		if (be[1])
			regs[sel][15:8] <= data[15:8];
	end

	assign x = regs[0];
	assign y = regs[1];
	assign z = regs[2];

endmodule

//--- design/pc_unit.sv
`timescale 1ns/1ps

module pc_unit #(
	parameter cpu_pkg::word_t reset_pc = 16'h4000
) (
	input logic clk,
	input logic reset,
	input cpu_pkg::ctrl_t ctrl,
	input cpu_pkg::byte_t disp,
	input cpu_pkg::flags_t flags,
	output cpu_pkg::word_t pc
);
	import cpu_pkg::*;

	logic taken;

	always_comb
	begin
		case (ctrl.cond)
			cond_always: taken = 1'b1;
			cond_z: taken = flags.z;
			cond_nz: taken = !flags.z;
			cond_c: taken = flags.c;
			cond_nc: taken = !flags.c;
			default: taken = 1'b0;
		endcase
	end

	// jump target is relative to the jump itself
	always_ff @(posedge clk)
	begin
		if (reset)
			pc <= reset_pc;
		else if (taken)
			pc <= pc + {{8{disp[7]}}, disp};
		else
			pc <= pc + word_t'(ctrl.len);
	end

endmodule

//--- design/cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
	parameter cpu_pkg::word_t reset_pc = 16'h4000
) (
	input logic clk,
	input logic reset,
	output cpu_pkg::word_t iread_addr,
	input cpu_pkg::inst_u iread_data,
	output cpu_pkg::word_t dread_addr,
	input cpu_pkg::word_t dread_data,
	output cpu_pkg::word_t dwrite_addr,
	output cpu_pkg::word_t dwrite_data,
	output logic [1:0] dwrite_en,
	output logic trap
);
	import cpu_pkg::*;

	ctrl_t ctrl;
	word_t x;
	word_t y;
	word_t result;
	word_t mem_addr;
	word_t reg_data;
	flags_t flags_out;
	flags_t flags;
	logic [1:0] reg_sel;
	logic [1:0] reg_be;

	assign trap = ctrl.trap;

	decoder u_decoder (.inst(iread_data), .reset(reset), .ctrl(ctrl));

	alu u_alu (
		.ctrl(ctrl), .inst(iread_data), .x(x), .y(y), .dread_data(dread_data),
		.result(result), .flags_out(flags_out)
	);

	addr_gen u_addr_gen (
		.ctrl(ctrl), .inst(iread_data), .y(y),
		.dread_addr(dread_addr), .dwrite_addr(mem_addr)
	);

	writeback u_writeback (
		.clk(clk), .reset(reset), .ctrl(ctrl), .result(result), .flags_out(flags_out),
		.x(x), .mem_addr(mem_addr), .reg_sel(reg_sel), .reg_be(reg_be),
		.reg_data(reg_data), .dwrite_addr(dwrite_addr), .dwrite_data(dwrite_data),
		.dwrite_en(dwrite_en), .flags(flags)
	);

	regfile u_regfile (
		.clk(clk), .sel(reg_sel), .be(reg_be), .data(reg_data), .x(x), .y(y), .z()
	);

	pc_unit #(.reset_pc(reset_pc)) u_pc_unit (
		.clk(clk), .reset(reset), .ctrl(ctrl), .disp(iread_data.s.imm8),
		.flags(flags), .pc(iread_addr)
	);

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	input logic restart,
	output logic clk,
	output logic reset
);
	logic [3:0] count = 4'd8;

	initial
	begin
		clk = 1'b0;
		forever
			#4 clk = ~clk;
	end

	always @(posedge clk)
	begin
		if (restart)
			count <= 4'd8;
		else if (count != 4'd0)
			count <= count - 4'd1;
	end

	// restart takes effect at once, then the count holds reset 8 more cycles
	assign reset = (count != 4'd0) || restart;

endmodule

//--- tests/cpu_assert.sv
`timescale 1ns/1ps

module cpu_assert #(
	parameter cpu_pkg::word_t reset_pc = 16'h4000
) (
	input logic clk,
	input logic reset,
	input cpu_pkg::word_t iread_addr,
	input logic [1:0] dwrite_en,
	input logic trap
);

	// next fetch moves past the 2 or 3 bytes of the store
	a_store_step: assert property (@(posedge clk)
		dwrite_en[0] |=> ((iread_addr == $past(iread_addr) + 16'd2)
			|| (iread_addr == $past(iread_addr) + 16'd3)))
		else $error("fetch after a data write did not follow the store instruction");

	a_quiet_in_reset: assert property (@(posedge clk) reset |-> (dwrite_en == 2'b00) && !trap)
		else $error("data write or trap while in reset");

	a_start_vector: assert property (@(posedge clk) $fell(reset) |-> iread_addr == reset_pc)
		else $error("first fetch after reset is not at the start address");

endmodule

bind cpu_top cpu_assert #(.reset_pc(reset_pc)) u_cpu_assert (
	.clk(clk), .reset(reset), .iread_addr(iread_addr), .dwrite_en(dwrite_en), .trap(trap)
);

//--- tests/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;
	import cpu_pkg::*;

	localparam word_t reset_pc = 16'h4000;
	localparam int n_random = 50;
	localparam int n_runs = n_random + 1 + 8 + 6 + 1;
	// 40 instructions per run plus 9 cycles of reset
	localparam int timeout_ns = n_runs * (40 + 9) * 8;

	typedef struct packed {
		word_t addr;
		byte_t data;
	} wr_t;

	typedef struct packed {
		flags_t f;
		byte_t r;
	} alu_ref_t;

	logic clk;
	logic reset;
	logic restart = 1'b0;
	word_t iread_addr;
	inst_u iread_data;
	word_t dread_addr;
	word_t dread_data;
	word_t dwrite_addr;
	word_t dwrite_data;
	logic [1:0] dwrite_en;
	logic trap;

	byte_t imem [65536];
	byte_t dmem [65536];
	wr_t exp_q [$];
	word_t asm_pc;
	string test_name = "reset";

	// immediate forms, the direct form is the next opcode up
	opcode_t alu_ops [7] = '{op_add_xl_immd, op_sub_xl_immd, op_and_xl_immd,
		op_or_xl_immd, op_xor_xl_immd, op_cp_xl_immd, op_inc_xl};

	// branch cases: jump, flag-setting op, xl, operand
	opcode_t br_ops [8] = '{op_jrz_d, op_jrz_d, op_jrnz_d, op_jrnz_d,
		op_jrc_d, op_jrc_d, op_jrnc_d, op_jrnc_d};
	opcode_t br_alu [8] = '{op_cp_xl_immd, op_cp_xl_immd, op_cp_xl_immd, op_add_xl_immd,
		op_cp_xl_immd, op_add_xl_immd, op_add_xl_immd, op_cp_xl_immd};
	byte_t br_a [8] = '{8'h42, 8'h42, 8'h10, 8'h80, 8'h10, 8'h01, 8'hff, 8'h30};
	byte_t br_b [8] = '{8'h42, 8'h43, 8'h20, 8'h80, 8'h20, 8'h02, 8'h01, 8'h20};

	tb_clock u_clock (.restart(restart), .clk(clk), .reset(reset));

	cpu_top #(.reset_pc(reset_pc)) u_dut (
		.clk(clk), .reset(reset), .iread_addr(iread_addr), .iread_data(iread_data),
		.dread_addr(dread_addr), .dread_data(dread_data), .dwrite_addr(dwrite_addr),
		.dwrite_data(dwrite_data), .dwrite_en(dwrite_en), .trap(trap)
	);

	// single-cycle memories
	assign iread_data = {imem[iread_addr + 16'd2], imem[iread_addr + 16'd1], imem[iread_addr]};
	assign dread_data = {dmem[dread_addr + 16'd1], dmem[dread_addr]};

	always @(posedge clk)
	begin
		if (dwrite_en[0])
			dmem[dwrite_addr] <= dwrite_data[7:0];
		if (dwrite_en[1])
			dmem[dwrite_addr + 16'd1] <= dwrite_data[15:8];
	end

	function automatic byte_t fill_byte(word_t a);
		return a[7:0] ^ a[15:8] ^ 8'h5c;
	endfunction

	initial
	begin
		for (int i = 0; i < 65536; i++)
			dmem[word_t'(i)] = fill_byte(word_t'(i));
	end

	function automatic alu_ref_t ref_alu8(opcode_t op, byte_t a, byte_t b, flags_t cur);
		alu_ref_t res;
		int sa;
		int sb;
		int wide;

		sa = int'($signed(a));
		sb = int'($signed(b));
		wide = 0;
		res.f = cur;
		case (op)
			op_add_xl_immd:
			begin
				res.r = a + b;
				res.f.c = (int'(a) + int'(b)) > 255;
				wide = sa + sb;
				res.f.o = (wide > 127) || (wide < -128);
			end
			op_sub_xl_immd, op_cp_xl_immd:
			begin
				res.r = a - b;
				// borrow
				res.f.c = a < b;
				wide = sa - sb;
				res.f.o = (wide > 127) || (wide < -128);
			end
			op_and_xl_immd: res.r = a & b;
			op_or_xl_immd: res.r = a | b;
			op_xor_xl_immd: res.r = a ^ b;
			op_inc_xl:
			begin
				res.r = a + 8'd1;
				res.f.c = (a == 8'hff);
				res.f.o = (a == 8'h7f);
			end
			default: res.r = b;
		endcase
		// inc leaves n alone
		if (op != op_inc_xl)
			res.f.n = res.r[7];
		res.f.z = (res.r == 8'h00);
		return res;
	endfunction

	task automatic check(input string name, input word_t expected, input word_t actual);
		if (expected !== actual)
		begin
			$display("Error: %s expected %h actual %h", name, expected, actual);
			$display("Simulation FAILED");
			$fatal(1);
		end
	endtask

	task automatic assemble(input opcode_t op, input word_t operand, input int len);
		imem[asm_pc] = op;
		if (len > 1)
			imem[asm_pc + 16'd1] = operand[7:0];
		if (len > 2)
			imem[asm_pc + 16'd2] = operand[15:8];
		asm_pc = asm_pc + word_t'(len);
	endtask

	task automatic expect_write(input word_t a, input byte_t d);
		exp_q.push_back(wr_t'{addr: a, data: d});
	endtask

	task automatic run_program(input string name, input word_t trap_at);
		test_name = name;
		@(negedge clk);
		while (reset)
		begin
			check($sformatf("%s dwrite_en in reset", name), 16'h0000, {14'h0, dwrite_en});
			check($sformatf("%s trap in reset", name), 16'h0000, {15'h0, trap});
			@(negedge clk);
		end
		check($sformatf("%s start address", name), reset_pc, iread_addr);
		while (trap !== 1'b1)
			@(negedge clk);
		check($sformatf("%s trap address", name), trap_at, iread_addr);
		// back into reset before the next program
		@(posedge clk);
		restart <= 1'b1;
		@(posedge clk);
		restart <= 1'b0;
		check($sformatf("%s writes left", name), 16'h0000, word_t'(exp_q.size()));
	endtask

	// compare each data write with the next expected one
	always @(negedge clk)
	begin
		wr_t exp_wr;

		if (dwrite_en != 2'b00)
		begin
			if (exp_q.size() == 0)
			begin
				$display("%s: the CPU wrote data memory where no write was expected", test_name);
				$display("Simulation FAILED");
				$fatal(1);
			end
			else
			begin
				exp_wr = exp_q.pop_front();
				check($sformatf("%s write address", test_name), exp_wr.addr, dwrite_addr);
				check($sformatf("%s write data", test_name), {8'h00, exp_wr.data},
					{8'h00, dwrite_data[7:0]});
				check($sformatf("%s write enables", test_name), 16'h0001, {14'h0, dwrite_en});
			end
		end
	end

	initial
	begin
		#(timeout_ns);
		$display("timeout: the CPU did not reach its trap instruction in time");
		$display("Simulation FAILED");
		$fatal(1);
	end

	initial
	begin
		alu_ref_t ref_res;
		opcode_t op;
		byte_t a;
		byte_t b;
		byte_t d;
		word_t addr;
		word_t ybase;
		word_t jump_at;
		logic taken;

		void'($urandom(32'h07fd_abb8));

		// immediate operands
		for (int i = 0; i < n_random; i++)
		begin
			op = alu_ops[3'($urandom() % 7)];
			a = 8'($urandom());
			b = 8'($urandom());
			addr = 16'h1000 | word_t'($urandom() % 32'h1000);
			ref_res = ref_alu8(op, a, b, '0);
			asm_pc = reset_pc;
			assemble(op_ld_xl_immd, {8'h00, a}, 2);
			if (op == op_inc_xl)
				assemble(op, 16'h0000, 1);
			else
				assemble(op, {8'h00, b}, 2);
			assemble(op_ld_dir_xl, addr, 3);
			assemble(op_trap, 16'h0000, 1);
			expect_write(addr, (op == op_cp_xl_immd) ? a : ref_res.r);
			run_program($sformatf("random %0d", i), asm_pc - 16'd1);
		end

		// y-relative store and load, then ldw x,y
		ybase = 16'h3000 | word_t'($urandom() % 32'h800);
		d = 8'($urandom());
		a = 8'($urandom());
		addr = 16'h2000 | word_t'($urandom() % 32'h1000);
		asm_pc = reset_pc;
		assemble(op_ldw_y_immd, ybase, 3);
		assemble(op_ld_xl_immd, {8'h00, a}, 2);
		assemble(op_ld_yrel_xl, {8'h00, d}, 2);
		assemble(op_ld_xl_immd, {8'h00, ~a}, 2);
		assemble(op_ld_xl_yrel, {8'h00, d}, 2);
		assemble(op_ld_dir_xl, addr, 3);
		assemble(op_ldw_x_y, 16'h0000, 1);
		assemble(op_ld_dir_xl, addr + 16'd1, 3);
		assemble(op_trap, 16'h0000, 1);
		expect_write(ybase + {8'h00, d}, a);
		expect_write(addr, a);
		expect_write(addr + 16'd1, ybase[7:0]);
		run_program("y-relative", asm_pc - 16'd1);

		// conditional jumps, target sits 8 bytes past the jump
		for (int i = 0; i < 8; i++)
		begin
			ref_res = ref_alu8(br_alu[3'(i)], br_a[3'(i)], br_b[3'(i)], '0);
			case (br_ops[3'(i)])
				op_jrz_d: taken = ref_res.f.z;
				op_jrnz_d: taken = !ref_res.f.z;
				op_jrc_d: taken = ref_res.f.c;
				default: taken = !ref_res.f.c;
			endcase
			asm_pc = reset_pc;
			assemble(op_ld_xl_immd, {8'h00, br_a[3'(i)]}, 2);
			assemble(br_alu[3'(i)], {8'h00, br_b[3'(i)]}, 2);
			jump_at = asm_pc;
			assemble(br_ops[3'(i)], 16'h0008, 2);
			assemble(op_ld_xl_immd, {8'h00, 8'h50 + byte_t'(i)}, 2);
			assemble(op_ld_dir_xl, 16'h0200 + word_t'(i), 3);
			assemble(op_trap, 16'h0000, 1);
			assemble(op_ld_xl_immd, {8'h00, 8'ha0 + byte_t'(i)}, 2);
			assemble(op_ld_dir_xl, 16'h0200 + word_t'(i), 3);
			assemble(op_trap, 16'h0000, 1);
			expect_write(16'h0200 + word_t'(i), taken ? 8'ha0 + byte_t'(i) : 8'h50 + byte_t'(i));
			run_program($sformatf("branch %0d", i), taken ? jump_at + 16'd13 : jump_at + 16'd7);
		end

		// direct memory operands
		for (int i = 0; i < 6; i++)
		begin
			op = alu_ops[3'(i)];
			a = 8'($urandom());
			addr = 16'h6000 | word_t'($urandom() % 32'h1000);
			ref_res = ref_alu8(op, a, fill_byte(addr), '0);
			asm_pc = reset_pc;
			assemble(op_ld_xl_immd, {8'h00, a}, 2);
			assemble(opcode_t'(byte_t'(op) + 8'd1), addr, 3);
			assemble(op_ld_dir_xl, 16'h7000 + word_t'(i), 3);
			assemble(op_trap, 16'h0000, 1);
			expect_write(16'h7000 + word_t'(i), (op == op_cp_xl_immd) ? a : ref_res.r);
			run_program($sformatf("memory operand %0d", i), asm_pc - 16'd1);
		end

		// jr over a store straight onto the trap
		asm_pc = reset_pc;
		assemble(op_ld_xl_immd, 16'h0077, 2);
		jump_at = asm_pc;
		assemble(op_jr_d, 16'h0005, 2);
		assemble(op_ld_dir_xl, 16'h0300, 3);
		assemble(op_trap, 16'h0000, 1);
		run_program("trap", jump_at + 16'd5);

		if (exp_q.size() != 0)
		begin
			$display("some expected data writes never happened");
			$display("Simulation FAILED");
			$fatal(1);
		end
		else
		begin
			$display("Simulation PASSED");
			$finish;
		end
	end

endmodule

//--- vlog.f
design/cpu_pkg.sv
design/decoder.sv
design/alu.sv
design/addr_gen.sv
design/writeback.sv
design/regfile.sv
design/pc_unit.sv
design/cpu_top.sv
tests/tb_clock.sv
tests/cpu_assert.sv
tests/cpu_tb.sv

//--- Makefile
SRCS := $(shell cat vlog.f)

.PHONY: all run clean

all: run

obj_dir/Vcpu_tb: vlog.f $(SRCS)
	verilator --binary --assert --top-module cpu_tb -f vlog.f -o Vcpu_tb

run: obj_dir/Vcpu_tb
	./obj_dir/Vcpu_tb > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Simulation FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
